// ==== Makefile ====
# Verilator build and run for the PMA unit testbench

VERILATOR ?= verilator
TOP       ?= pma_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

SIM_EXE = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# The exit status comes from the search for the pass line
run: compile
	@out=$$(./$(SIM_EXE)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
+incdir+hdl
hdl/pma_pkg.sv
hdl/pma_cfg_if.sv
hdl/pma_cfg_regs.sv
hdl/pma_check.sv
hdl/pma_unit_top.sv
test/pma_monitor.sv
test/pma_tb.sv

// ==== hdl/pma_cfg_if.sv ====
/*
 * PMA configuration interface
 * Region table, enables and default attributes from registers to checker
 */
`timescale 1ns/100ps
`include "pma_config.svh"

interface pma_cfg_if import pma_pkg::*; ();

  // Programmed regions
  pma_table_t                  regions;

  // Set when high bound is above low bound
  logic [`PMA_NUM_REGIONS-1:0] region_en;

  // Attributes for an address with no hit
  pma_attr_t                   attr_default;

  // Register block side
  modport source (
    output regions,
    output region_en,
    output attr_default
  );

  // Checker side
  modport sink (
    input regions,
    input region_en,
    input attr_default
  );

endinterface

// ==== hdl/pma_cfg_regs.sv ====
/*
 * PMA region table
 * Run-time programmable bounds and attributes with a field write port
 */
`timescale 1ns/100ps
`include "pma_config.svh"

module pma_cfg_regs import pma_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cfg_we_i,
  input  logic [`PMA_IDX_W-1:0] cfg_idx_i,
  input  pma_field_e            cfg_sel_i,
  input  logic [31:0]           cfg_wdata_i,
  pma_cfg_if.source             cfg
);

  // Table needs at least one region
  if (`PMA_NUM_REGIONS < 1) begin : g_bad_cfg
    $error("PMA_NUM_REGIONS must be at least 1");
  end

  pma_table_t                  regions_q;
  logic [`PMA_NUM_REGIONS-1:0] region_en_q;

  // Entry after the write is applied
  pma_region_t                 wr_region;
  logic                        wr_en;
  logic                        wr_valid;

  ////////////////////
  // Write decode
  ////////////////////

  // Reserved field leaves the table alone
  assign wr_valid = cfg_we_i && (cfg_sel_i != PMA_FIELD_RSVD);

  always_comb begin
    // Start from the current entry
    wr_region = regions_q[cfg_idx_i];
    case (cfg_sel_i)
      PMA_FIELD_LOW: begin
        wr_region.word_addr_low = cfg_wdata_i;
      end
      PMA_FIELD_HIGH: begin
        wr_region.word_addr_high = cfg_wdata_i;
      end
      PMA_FIELD_ATTR: begin
        // main, bufferable, cacheable, integrity, atomic from bit 4 down
        wr_region.attr = pma_attr_t'(cfg_wdata_i[PMA_ATTR_W-1:0]);
      end
      default: begin
      end
    endcase
  end

  // Region enable from the new bounds
  // High bound is exclusive so equal bounds cover nothing
  assign wr_en = wr_region.word_addr_high > wr_region.word_addr_low;

  ////////////////////
  // Table storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      // All regions empty, every address falls to the default
      regions_q   <= '0;
      region_en_q <= '0;
    end else if (wr_valid) begin
      regions_q[cfg_idx_i]   <= wr_region;
      region_en_q[cfg_idx_i] <= wr_en;
    end
  end

  ////////////////////
  // Interface drive
  ////////////////////

  assign cfg.regions      = regions_q;
  assign cfg.region_en    = region_en_q;
  assign cfg.attr_default = PMA_ATTR_DEFAULT;

  // Software must stay inside the implemented table
  a_idx_in_range : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    cfg_we_i |-> (int'(cfg_idx_i) < `PMA_NUM_REGIONS)
  ) else $error("PMA write to region %0d beyond table", cfg_idx_i);

endmodule

// ==== hdl/pma_check.sv ====
/*
 * PMA checker
 * Region match, access rules and attribute outputs, one cycle latency
 */
`timescale 1ns/100ps
`include "pma_config.svh"

module pma_check import pma_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  pma_cfg_if.sink                cfg,

  // Request
  input  logic                   req_valid_i,
  input  logic [`PMA_ADDR_W-1:0] req_addr_i,
  input  logic                   req_debug_region_i,  // Address inside debug module range
  input  logic                   req_pushpop_i,
  input  logic                   req_fetch_i,
  input  logic                   req_misaligned_i,
  input  logic                   req_load_i,
  input  logic                   req_atomic_i,

  // Response
  output logic                   rsp_valid_o,
  output logic                   rsp_err_o,
  output logic                   rsp_integrity_o,
  output logic                   rsp_bufferable_o,
  output logic                   rsp_cacheable_o
);

  logic [31:0] word_addr;
  pma_attr_t   attr;
  logic        err_d;
  logic        bufferable_d;

  // Bounds are held as word addresses
  assign word_addr = {2'b00, req_addr_i[31:2]};

  ////////////////////
  // Region select
  ////////////////////

  always_comb begin
    // No hit falls back to the default word
    attr = cfg.attr_default;

    // Walk downward so the lowest index is written last
    for (int i = `PMA_NUM_REGIONS-1; i >= 0; i--) begin
      if (cfg.region_en[i] &&
          (word_addr >= cfg.regions[i].word_addr_low) &&
          (word_addr <  cfg.regions[i].word_addr_high)) begin
        attr = cfg.regions[i].attr;
      end
    end

    // Debug module range overrides the table
    if (req_debug_region_i) begin
      attr = PMA_ATTR_DEBUG;
    end
  end

  ////////////////////
  // Access rules
  ////////////////////

  always_comb begin
    err_d = 1'b0;

    // Atomics need the atomic attribute
    if (req_atomic_i && !attr.atomic) begin
      err_d = 1'b1;
    end

    // Atomics must be aligned
    if (req_atomic_i && req_misaligned_i) begin
      err_d = 1'b1;
    end

    // Fetch only from main memory
    if (req_fetch_i && !attr.main) begin
      err_d = 1'b1;
    end

    // No split access to I/O
    if (req_misaligned_i && !attr.main) begin
      err_d = 1'b1;
    end

    // Push and pop stay in main memory
    if (req_pushpop_i && !attr.main) begin
      err_d = 1'b1;
    end
  end

  // Fetches and loads are never bufferable
  assign bufferable_d = attr.bufferable && !req_fetch_i && !req_load_i;

  ////////////////////
  // Response stage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rsp_valid_o      <= 1'b0;
      rsp_err_o        <= 1'b0;
      rsp_integrity_o  <= 1'b0;
      rsp_bufferable_o <= 1'b0;
      rsp_cacheable_o  <= 1'b0;
    end else begin
      // Idle cycles give an all-zero response
      rsp_valid_o      <= req_valid_i;
      rsp_err_o        <= req_valid_i && err_d;
      rsp_integrity_o  <= req_valid_i && attr.integrity;
      rsp_bufferable_o <= req_valid_i && bufferable_d;
      rsp_cacheable_o  <= req_valid_i && attr.cacheable;
    end
  end

  // No response left over from before reset
  a_no_rsp_after_rst : assert property (
    @(posedge clk_i) !rst_n_i |=> !rsp_valid_o
  ) else $error("PMA response valid right after reset");

  // Error only comes with a response
  a_err_needs_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !rsp_valid_o |-> !rsp_err_o
  ) else $error("PMA error without a response");

endmodule

// ==== hdl/pma_config.svh ====
/*
 * PMA configuration constants
 * Region count, widths and debug module bounds
 */
`ifndef PMA_CONFIG_SVH
`define PMA_CONFIG_SVH

// Number of programmable regions
`define PMA_NUM_REGIONS 4

// Width of the region index on the write port
`define PMA_IDX_W 2

// Byte address width of a request
`define PMA_ADDR_W 32

// Debug module region in word addresses
// High bound is exclusive
// The region hit itself is flagged by the core
`define PMA_DBG_LOW 32'h0000_0400
`define PMA_DBG_HIGH 32'h0000_0600

`endif

// ==== hdl/pma_pkg.sv ====
/*
 * PMA package
 * Attribute, region and field-select types with fixed attribute words
 */
`include "pma_config.svh"

package pma_pkg;

  // Attribute bits of one region
  // Bit order matches the write data layout 4 down to 0
  typedef struct packed {
    logic main;
    logic bufferable;
    logic cacheable;
    logic integrity;
    logic atomic;
  } pma_attr_t;

  localparam int PMA_ATTR_W = $bits(pma_attr_t);

  // One region entry, bounds are word addresses
  typedef struct packed {
    logic [31:0] word_addr_low;
    logic [31:0] word_addr_high;
    pma_attr_t   attr;
  } pma_region_t;

  // Whole region table
  typedef pma_region_t [`PMA_NUM_REGIONS-1:0] pma_table_t;

  // Field written by a configuration access
  typedef enum logic [1:0] {
    PMA_FIELD_LOW  = 2'd0,
    PMA_FIELD_HIGH = 2'd1,
    PMA_FIELD_ATTR = 2'd2,
    PMA_FIELD_RSVD = 2'd3
  } pma_field_e;

  // No region hit, I/O with nothing allowed
  localparam pma_attr_t PMA_ATTR_DEFAULT = '0;

  // Debug module range, main memory only
  localparam pma_attr_t PMA_ATTR_DEBUG = '{main: 1'b1, default: 1'b0};

endpackage

// ==== hdl/pma_unit_top.sv ====
/*
 * PMA unit top level
 * Region table registers beside the access checker
 */
`timescale 1ns/100ps
`include "pma_config.svh"

module pma_unit_top import pma_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_n_i,

  // Configuration write
  input  logic                   cfg_we_i,
  input  logic [`PMA_IDX_W-1:0]  cfg_idx_i,
  input  pma_field_e             cfg_sel_i,
  input  logic [31:0]            cfg_wdata_i,

  // Request
  input  logic                   req_valid_i,
  input  logic [`PMA_ADDR_W-1:0] req_addr_i,
  input  logic                   req_debug_region_i,
  input  logic                   req_pushpop_i,
  input  logic                   req_fetch_i,
  input  logic                   req_misaligned_i,
  input  logic                   req_load_i,
  input  logic                   req_atomic_i,

  // Response, one cycle after the request
  output logic                   rsp_valid_o,
  output logic                   rsp_err_o,
  output logic                   rsp_integrity_o,
  output logic                   rsp_bufferable_o,
  output logic                   rsp_cacheable_o
);

  // Table path from registers to checker
  pma_cfg_if i_cfg_if ();

  ////////////////////
  // Region table
  ////////////////////

  pma_cfg_regs i_cfg_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_idx_i   (cfg_idx_i),
    .cfg_sel_i   (cfg_sel_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg         (i_cfg_if.source)
  );

  ////////////////////
  // Checker
  ////////////////////

  pma_check i_check (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .cfg                (i_cfg_if.sink),
    .req_valid_i        (req_valid_i),
    .req_addr_i         (req_addr_i),
    .req_debug_region_i (req_debug_region_i),
    .req_pushpop_i      (req_pushpop_i),
    .req_fetch_i        (req_fetch_i),
    .req_misaligned_i   (req_misaligned_i),
    .req_load_i         (req_load_i),
    .req_atomic_i       (req_atomic_i),
    .rsp_valid_o        (rsp_valid_o),
    .rsp_err_o          (rsp_err_o),
    .rsp_integrity_o    (rsp_integrity_o),
    .rsp_bufferable_o   (rsp_bufferable_o),
    .rsp_cacheable_o    (rsp_cacheable_o)
  );

endmodule

// ==== test/pma_monitor.sv ====
/*
 * PMA response monitor
 * Mirrors the region table and checks every response against a reference model
 */
`timescale 1ns/100ps
`include "pma_config.svh"

module pma_monitor (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  cfg_we_i,
  input  logic [`PMA_IDX_W-1:0] cfg_idx_i,
  input  logic [1:0]            cfg_sel_i,
  input  logic [31:0]           cfg_wdata_i,
  input  logic                  req_valid_i,
  input  logic [31:0]           req_addr_i,
  input  logic                  req_debug_region_i,
  input  logic                  req_pushpop_i,
  input  logic                  req_fetch_i,
  input  logic                  req_misaligned_i,
  input  logic                  req_load_i,
  input  logic                  req_atomic_i,
  input  logic                  rsp_valid_o,
  input  logic                  rsp_err_o,
  input  logic                  rsp_integrity_o,
  input  logic                  rsp_bufferable_o,
  input  logic                  rsp_cacheable_o,
  output int                    value_errs_o,
  output int                    proto_errs_o,
  output int                    rsp_cnt_o
);

  localparam int NUM_REGIONS = `PMA_NUM_REGIONS;

  // Attribute word bits from main down to atomic
  localparam int A_MAIN   = 4;
  localparam int A_BUF    = 3;
  localparam int A_CACHE  = 2;
  localparam int A_INTEG  = 1;
  localparam int A_ATOMIC = 0;

  // No hit means I/O with nothing allowed
  localparam logic [4:0] ATTR_NONE = 5'b00000;
  // Debug module is plain main memory
  localparam logic [4:0] ATTR_DBG  = 5'b10000;

  // Mirror of the region table
  logic [31:0] low_m  [NUM_REGIONS];
  logic [31:0] high_m [NUM_REGIONS];
  logic [4:0]  attr_m [NUM_REGIONS];

  // Expected response of the request taken on the last edge
  logic        exp_pending;
  logic        exp_err;
  logic        exp_integ;
  logic        exp_buf;
  logic        exp_cache;
  logic [31:0] exp_addr;

  int value_errs = 0;
  int proto_errs = 0;
  int rsp_cnt    = 0;

  assign value_errs_o = value_errs;
  assign proto_errs_o = proto_errs;
  assign rsp_cnt_o    = rsp_cnt;

  // First enabled region that covers the word wins
  function automatic logic [4:0] region_attr(input logic [31:0] word);
    logic [4:0] a;
    logic       hit;
    a   = ATTR_NONE;
    hit = 1'b0;
    for (int r = 0; r < NUM_REGIONS; r++) begin
      if (!hit && (high_m[r] > low_m[r]) && (word >= low_m[r]) && (word < high_m[r])) begin
        a   = attr_m[r];
        hit = 1'b1;
      end
    end
    return a;
  endfunction

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Fail %s: expected 0x%h, got 0x%h (addr 0x%h, %0t)",
               name, exp, act, exp_addr, $time);
      value_errs++;
    end
  endtask

  ////////////////////
  // Checking
  ////////////////////

  always @(posedge clk_i) begin : p_check
    logic [4:0]  attr;
    logic [31:0] word;
    if (!rst_n_i) begin
      // Table comes out of reset empty
      for (int r = 0; r < NUM_REGIONS; r++) begin
        low_m[r]  = '0;
        high_m[r] = '0;
        attr_m[r] = '0;
      end
      exp_pending = 1'b0;
    end else begin
      // Response to the request of the previous edge
      if (exp_pending) begin
        if (rsp_valid_o !== 1'b1) begin
          $display("Missing response to request at addr 0x%h (%0t)", exp_addr, $time);
          proto_errs++;
        end else begin
          rsp_cnt++;
          compare_bit("rsp_err_o", exp_err, rsp_err_o);
          compare_bit("rsp_integrity_o", exp_integ, rsp_integrity_o);
          compare_bit("rsp_bufferable_o", exp_buf, rsp_bufferable_o);
          compare_bit("rsp_cacheable_o", exp_cache, rsp_cacheable_o);
        end
      end else if (rsp_valid_o !== 1'b0) begin
        $display("Response appeared with no request behind it (%0t)", $time);
        proto_errs++;
      end

      // New request sees the table before this edge's write
      exp_pending = req_valid_i;
      if (req_valid_i) begin
        word = req_addr_i >> 2;
        attr = req_debug_region_i ? ATTR_DBG : region_attr(word);
        exp_err = (req_atomic_i && !attr[A_ATOMIC]) ||
                  (req_atomic_i && req_misaligned_i) ||
                  (req_fetch_i && !attr[A_MAIN]) ||
                  (req_misaligned_i && !attr[A_MAIN]) ||
                  (req_pushpop_i && !attr[A_MAIN]);
        exp_integ = attr[A_INTEG];
        exp_cache = attr[A_CACHE];
        // Loads and fetches never buffered
        exp_buf   = attr[A_BUF] && !req_fetch_i && !req_load_i;
        exp_addr  = req_addr_i;
      end

      // Table write takes effect after this edge
      if (cfg_we_i) begin
        case (cfg_sel_i)
          2'd0: begin
            low_m[cfg_idx_i] = cfg_wdata_i;
          end
          2'd1: begin
            high_m[cfg_idx_i] = cfg_wdata_i;
          end
          2'd2: begin
            attr_m[cfg_idx_i] = cfg_wdata_i[4:0];
          end
          default: begin
          end
        endcase
      end
    end
  end

endmodule

// ==== test/pma_tb.sv ====
/*
 * PMA unit testbench
 * Random table writes and requests from an LFSR, checked by the monitor
 */
`timescale 1ns/100ps
`include "pma_config.svh"

module pma_tb import pma_pkg::*; ();

  localparam int NUM_REGIONS = `PMA_NUM_REGIONS;
  localparam int IDX_W       = `PMA_IDX_W;

  // Test phases in cycles
  localparam int RESET_CYCLES = 16;
  localparam int DEFAULT_REQS = 200;
  localparam int CFG_WRITES   = 40;
  localparam int TABLE_REQS   = 2800;
  localparam int MIXED_CYCLES = 2000;
  localparam int DRAIN_CYCLES = 3;
  localparam int TEST_CYCLES  = RESET_CYCLES + DEFAULT_REQS + CFG_WRITES +
                                TABLE_REQS + MIXED_CYCLES + DRAIN_CYCLES;
  // Rounded up to the next thousand
  localparam int TIMEOUT_CYCLES = ((TEST_CYCLES / 1000) + 1) * 1000;

  localparam logic [31:0] LFSR_SEED = 32'h517f;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic        cfg_we;
  logic [IDX_W-1:0] cfg_idx;
  pma_field_e  cfg_sel;
  logic [31:0] cfg_wdata;
  logic        req_valid;
  logic [31:0] req_addr;
  logic        req_debug;
  logic        req_pushpop;
  logic        req_fetch;
  logic        req_misaligned;
  logic        req_load;
  logic        req_atomic;
  logic        rsp_valid;
  logic        rsp_err;
  logic        rsp_integrity;
  logic        rsp_bufferable;
  logic        rsp_cacheable;

  int          value_errs;
  int          proto_errs;
  int          rsp_cnt;
  int          timeout_errs = 0;
  int          cycle_cnt;
  logic [31:0] lfsr_state;

  // Recently written bounds, reused as addresses to hit region edges
  logic [31:0] bound_q[$];

  initial clk = 1'b0;
  always #20 clk = ~clk;

  pma_unit_top i_dut (
    .clk_i (clk), .rst_n_i (rst_n),
    .cfg_we_i (cfg_we), .cfg_idx_i (cfg_idx), .cfg_sel_i (cfg_sel), .cfg_wdata_i (cfg_wdata),
    .req_valid_i (req_valid), .req_addr_i (req_addr), .req_debug_region_i (req_debug),
    .req_pushpop_i (req_pushpop), .req_fetch_i (req_fetch),
    .req_misaligned_i (req_misaligned), .req_load_i (req_load), .req_atomic_i (req_atomic),
    .rsp_valid_o (rsp_valid), .rsp_err_o (rsp_err), .rsp_integrity_o (rsp_integrity),
    .rsp_bufferable_o (rsp_bufferable), .rsp_cacheable_o (rsp_cacheable)
  );

  pma_monitor i_monitor (
    .clk_i (clk), .rst_n_i (rst_n),
    .cfg_we_i (cfg_we), .cfg_idx_i (cfg_idx), .cfg_sel_i (cfg_sel), .cfg_wdata_i (cfg_wdata),
    .req_valid_i (req_valid), .req_addr_i (req_addr), .req_debug_region_i (req_debug),
    .req_pushpop_i (req_pushpop), .req_fetch_i (req_fetch),
    .req_misaligned_i (req_misaligned), .req_load_i (req_load), .req_atomic_i (req_atomic),
    .rsp_valid_o (rsp_valid), .rsp_err_o (rsp_err), .rsp_integrity_o (rsp_integrity),
    .rsp_bufferable_o (rsp_bufferable), .rsp_cacheable_o (rsp_cacheable),
    .value_errs_o (value_errs), .proto_errs_o (proto_errs), .rsp_cnt_o (rsp_cnt)
  );

  ////////////////////
  // Random source
  ////////////////////

  // Galois LFSR stepped once per bit
  function automatic logic take_bit();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], take_bit()};
    end
    return v;
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic step_cycle(input bit req_on, input bit wr_on);
    logic [31:0] word;
    logic [31:0] data;
    logic [2:0]  pick_sel;
    logic [1:0]  field;
    int          pick;
    @(posedge clk);

    // Request address near region edges, in the bound window, or anywhere
    pick_sel = 3'(rand_bits(2));
    if (pick_sel == 3'd0 && bound_q.size() > 0) begin
      pick = int'(rand_bits(4)) % bound_q.size();
      // One below up to two above a bound
      word = bound_q[pick] + rand_bits(2) - 32'd1;
      req_addr <= (word << 2) | rand_bits(2);
    end else if (pick_sel == 3'd1) begin
      req_addr <= rand_bits(32);
    end else begin
      word = rand_bits(9);
      req_addr <= (word << 2) | rand_bits(2);
    end
    req_valid      <= req_on && (rand_bits(3) != 32'd0);
    req_debug      <= (rand_bits(3) == 32'd0);
    req_pushpop    <= take_bit();
    req_fetch      <= take_bit();
    req_misaligned <= take_bit();
    req_load       <= take_bit();
    req_atomic     <= take_bit();

    // Table write with the reserved field about one time in eight
    pick_sel = 3'(rand_bits(3));
    field    = (pick_sel == 3'd7) ? 2'd3 : 2'(pick_sel % 3'd3);
    if (field == 2'd2) begin
      data = rand_bits(32);
    end else if (rand_bits(4) == 32'd0) begin
      data = rand_bits(32);
    end else if (field == 2'd1) begin
      data = rand_bits(9);
    end else begin
      data = rand_bits(8);
    end
    if (wr_on && field < 2'd2) begin
      bound_q.push_back(data);
      if (bound_q.size() > 16) begin
        void'(bound_q.pop_front());
      end
    end
    cfg_we    <= wr_on;
    cfg_idx   <= IDX_W'(rand_bits(IDX_W) % NUM_REGIONS);
    cfg_sel   <= pma_field_e'(field);
    cfg_wdata <= data;
  endtask

  task automatic close_run();
    int total;
    // Counts settle after the monitor has seen the last edge
    @(negedge clk);
    total = value_errs + proto_errs + timeout_errs;
    if (rsp_cnt == 0) begin
      $display("No response was checked during the run");
      total++;
    end
    $display("Errors %0d (value %0d, protocol %0d, timeout %0d), responses checked %0d",
             total, value_errs, proto_errs, timeout_errs, rsp_cnt);
    if (total == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  initial begin : p_main
    lfsr_state     = LFSR_SEED;
    rst_n          = 1'b0;
    cfg_we         = 1'b0;
    cfg_idx        = '0;
    cfg_sel        = PMA_FIELD_LOW;
    cfg_wdata      = '0;
    req_valid      = 1'b0;
    req_addr       = '0;
    req_debug      = 1'b0;
    req_pushpop    = 1'b0;
    req_fetch      = 1'b0;
    req_misaligned = 1'b0;
    req_load       = 1'b0;
    req_atomic     = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    // Empty table gives defaults everywhere
    repeat (DEFAULT_REQS) step_cycle(1'b1, 1'b0);
    // Program regions
    repeat (CFG_WRITES) step_cycle(1'b0, 1'b1);
    // Lookups against a fixed table
    repeat (TABLE_REQS) step_cycle(1'b1, 1'b0);
    // Writes about one cycle in four among back-to-back requests
    repeat (MIXED_CYCLES) step_cycle(1'b1, rand_bits(2) == 32'd0);
    // Let the last response reach the monitor
    repeat (DRAIN_CYCLES) step_cycle(1'b0, 1'b0);

    close_run();
  end

  initial begin : p_timeout
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout, stimulus still running after %0d cycles", cycle_cnt);
    timeout_errs = 1;
    close_run();
  end

endmodule
